// File: verilog.f
+incdir+include
logic/gpioPkg.sv
logic/gpioRegBusIf.sv
logic/opbStrobeDecode.sv
logic/gpioRegisterBank.sv
logic/opbReadResult.sv
logic/gpioOpb.sv
tb/tbGpioOpb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Build the GPIO OPB testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simBinary=simGpioOpb
logFile=sim.log

verilator --binary -j 0 --top-module tbGpioOpb -f verilog.f -Mdir "$buildDir" -o "$simBinary"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/$simBinary" 2>&1 | tee "$logFile"
runStatus=${PIPESTATUS[0]}
if [ "$runStatus" -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

if grep -qx "Verification passed" "$logFile"; then
    echo "Simulation result: PASS"
    exit 0
else
    echo "Simulation result: FAIL"
    exit 1
fi

// File: include/gpioModel.svh
/*
 * Reference model of the GPIO register block
 *   Group words, read path with priority, edge update, ADC decode
 */
`ifndef GPIO_MODEL_SVH
`define GPIO_MODEL_SVH

gpioPkg::regWordT modelWords [gpioPkg::numGroups];

function automatic void resetWords();
    for (int g = 0; g < gpioPkg::numGroups; g++) begin
        modelWords[g] = gpioPkg::regResetValues[g];
    end
endfunction

// Expected opbDo after the edge, from the words before it
function automatic gpioPkg::regWordT expectedRead(logic [gpioPkg::numGroups-1:0] re);
    gpioPkg::regWordT word;
    word = '0;
    // Walk down so the lowest strobed group is kept
    for (int g = gpioPkg::numGroups - 1; g >= 0; g--) begin
        if (re[g]) begin
            word = modelWords[g];
        end
    end
    return word;
endfunction

// Status vectors are zero padded per group by the caller
function automatic void applyEdge(logic [gpioPkg::numGroups-1:0] we, gpioPkg::regWordT di,
                                  logic [gpioPkg::numGroups-1:0][15:0] status);
    for (int g = 0; g < gpioPkg::numGroups; g++) begin
        if (we[g]) begin
            modelWords[g][15:0] = di[15:0];
        end else begin
            modelWords[g][31:16] = status[g];
        end
    end
endfunction

function automatic logic [gpioPkg::adcMuxCount-1:0] expectedMuxN();
    logic [gpioPkg::adcMuxCount-1:0] lines;
    lines = '1;
    for (int m = 0; m < gpioPkg::adcMuxCount; m++) begin
        if (modelWords[gpioPkg::grpAdcSel][7:3] == gpioPkg::adcMuxCodes[m]) begin
            lines[m] = 1'b0;
        end
    end
    return lines;
endfunction

`endif

// File: tb/tbGpioOpb.sv
/*
 * Testbench for the OPB GPIO register block
 *   Clock, reset, random strobes, data and status pins
 *   Reference model compare, watchdog, pass/fail report
 */
`timescale 1ns/1ns

module tbGpioOpb;
    import gpioPkg::*;

    localparam int clkPeriod    = 4;
    localparam int resetCycles  = 4;
    localparam int randomCycles = 400;
    localparam int statusCycles = 200;
    localparam int readCycles   = 200;
    localparam int adcCycles    = 40;
    localparam int totalCycles  = 2 * resetCycles + 2 * numGroups + randomCycles
                                  + statusCycles + readCycles + adcCycles + adcMuxCount;

    logic OPB_CLK;
    logic OPB_RST;
    regWordT opbDi;
    regWordT opbDo;
    logic powerWe, gantry96vWe, spdEmopsWe, liftSensorWe, adcSelWe;
    logic powerRe, gantry96vRe, spdEmopsRe, liftSensorRe, adcSelRe;
    logic [powerStatusWidth-1:0]      powerStatus;
    logic [gantry96vStatusWidth-1:0]  gantry96vStatus;
    logic [spdEmopsStatusWidth-1:0]   spdEmopsStatus;
    logic [liftSensorStatusWidth-1:0] liftSensorStatus;
    logic [powerCtrlWidth-1:0]        powerCtrl;
    logic [gantry96vCtrlWidth-1:0]    gantry96vCtrl;
    logic [spdEmopsCtrlWidth-1:0]     spdEmopsCtrl;
    logic                             liftHallPwrEnN;
    logic [adcSelWidth-1:0]           adcSel;
    logic [adcMuxCount-1:0]           adcMuxN;

    `include "gpioModel.svh"

    gpioOpb i_gpioOpb (.*);

    always #(clkPeriod / 2) OPB_CLK = ~OPB_CLK;

    task automatic checkValue(input string name, input regWordT actual, input regWordT expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: actual 0x%08h expected 0x%08h", name, actual, expected);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic checkOutputs(input regWordT expDo);
        checkValue("opbDo", opbDo, expDo);
        checkValue("powerCtrl", 32'(powerCtrl), 32'(modelWords[grpPower][powerCtrlWidth-1:0]));
        checkValue("gantry96vCtrl", 32'(gantry96vCtrl),
                   32'(modelWords[grpGantry96v][gantry96vCtrlWidth-1:0]));
        checkValue("spdEmopsCtrl", 32'(spdEmopsCtrl),
                   32'(modelWords[grpSpdEmops][spdEmopsCtrlWidth-1:0]));
        checkValue("liftHallPwrEnN", 32'(liftHallPwrEnN), 32'(modelWords[grpLiftSensor][0]));
        checkValue("adcSel", 32'(adcSel), 32'(modelWords[grpAdcSel][adcSelWidth-1:0]));
        checkValue("adcMuxN", 32'(adcMuxN), 32'(expectedMuxN()));
    endtask

    // Called on a falling edge, returns on the next one
    task automatic stepCycle(input logic [numGroups-1:0] we, input logic [numGroups-1:0] re,
                             input regWordT di);
        logic [numGroups-1:0][15:0] status;
        int unsigned r;
        regWordT expDo;
        {adcSelWe, liftSensorWe, spdEmopsWe, gantry96vWe, powerWe} = we;
        {adcSelRe, liftSensorRe, spdEmopsRe, gantry96vRe, powerRe} = re;
        opbDi = di;
        r = $urandom;
        powerStatus = r[powerStatusWidth-1:0];
        r = $urandom;
        gantry96vStatus = r[gantry96vStatusWidth-1:0];
        r = $urandom;
        spdEmopsStatus = r[spdEmopsStatusWidth-1:0];
        r = $urandom;
        liftSensorStatus = r[liftSensorStatusWidth-1:0];
        status = '0;
        status[grpPower] = 16'(powerStatus);
        status[grpGantry96v] = 16'(gantry96vStatus);
        status[grpSpdEmops] = 16'(spdEmopsStatus);
        status[grpLiftSensor] = 16'(liftSensorStatus);
        expDo = expectedRead(re);
        applyEdge(we, di, status);
        @(negedge OPB_CLK);
        checkOutputs(expDo);
    endtask

    task automatic readEachGroup();
        for (int g = 0; g < numGroups; g++) begin
            stepCycle('0, numGroups'(1) << g, $urandom);
        end
    endtask

    // Watchdog
    initial begin
        #(2 * totalCycles * clkPeriod);
        $display("Timeout: the run did not finish within %0d ns", 2 * totalCycles * clkPeriod);
        $display("Verification failed");
        $fatal(1);
    end

    initial begin
        int unsigned r;
        int g;
        logic [numGroups-1:0] we;
        logic [numGroups-1:0] re;
        regWordT di;
        r = $urandom(75);
        OPB_CLK = 1'b0;
        OPB_RST = 1'b1;
        opbDi = '0;
        {powerWe, gantry96vWe, spdEmopsWe, liftSensorWe, adcSelWe} = '0;
        {powerRe, gantry96vRe, spdEmopsRe, liftSensorRe, adcSelRe} = '0;
        powerStatus = '0;
        gantry96vStatus = '0;
        spdEmopsStatus = '0;
        liftSensorStatus = '0;
        resetWords();
        repeat (resetCycles) @(negedge OPB_CLK);
        checkOutputs('0);
        OPB_RST = 1'b0;
        readEachGroup();

        // Random single and multiple writes with random reads
        repeat (randomCycles) begin
            r = $urandom;
            stepCycle(r[4:0] & r[9:5], r[14:10], $urandom);
        end

        ////////////////////////////////////////
        // Sparse writes, one group read back
        ////////////////////////////////////////
        repeat (statusCycles) begin
            r = $urandom;
            g = int'(r[31:8] % numGroups);
            re = '0;
            re[g] = 1'b1;
            stepCycle(r[4:0] & r[9:5] & r[14:10], re, $urandom);
        end

        // Read priority, and a write and read of one group in the same edge
        for (int c = 0; c < readCycles; c++) begin
            r = $urandom;
            if (c % 2 == 0) begin
                stepCycle('0, r[4:0] & r[9:5], $urandom);
            end else begin
                g = int'(r % numGroups);
                we = '0;
                we[g] = 1'b1;
                stepCycle(we, we, $urandom);
            end
        end

        ////////////////////////////////////////
        // ADC mux codes, then random fields
        ////////////////////////////////////////
        we = '0;
        we[grpAdcSel] = 1'b1;
        for (int m = 0; m < adcMuxCount; m++) begin
            di = $urandom;
            di[7:3] = ~(5'b00001 << m);
            stepCycle(we, '0, di);
        end
        for (int c = 0; c < adcCycles; c++) begin
            di = $urandom;
            stepCycle(we, we, di);
        end

        // Reset in the middle of a cycle, no clock edge needed
        OPB_RST = 1'b1;
        #1;
        resetWords();
        checkOutputs('0);
        repeat (resetCycles) @(negedge OPB_CLK);
        OPB_RST = 1'b0;
        readEachGroup();

        $display("Verification passed");
        $finish;
    end

endmodule

// File: logic/gpioOpb.sv
/*
 * OPB GPIO register block, top level
 *   Strobe decode, register bank and read result
 *   joined by the internal register bus
 */
`timescale 1ns/1ns

module gpioOpb (
    input  logic                                       OPB_CLK,
    input  logic                                       OPB_RST,
    input  gpioPkg::regWordT                           opbDi,
    output gpioPkg::regWordT                           opbDo,

    // Bus strobes
    input  logic                                       powerWe,
    input  logic                                       gantry96vWe,
    input  logic                                       spdEmopsWe,
    input  logic                                       liftSensorWe,
    input  logic                                       adcSelWe,
    input  logic                                       powerRe,
    input  logic                                       gantry96vRe,
    input  logic                                       spdEmopsRe,
    input  logic                                       liftSensorRe,
    input  logic                                       adcSelRe,

    // Subsystem status pins
    input  logic [gpioPkg::powerStatusWidth-1:0]       powerStatus,
    input  logic [gpioPkg::gantry96vStatusWidth-1:0]   gantry96vStatus,
    input  logic [gpioPkg::spdEmopsStatusWidth-1:0]    spdEmopsStatus,
    input  logic [gpioPkg::liftSensorStatusWidth-1:0]  liftSensorStatus,

    // Subsystem control pins
    output logic [gpioPkg::powerCtrlWidth-1:0]         powerCtrl,
    output logic [gpioPkg::gantry96vCtrlWidth-1:0]     gantry96vCtrl,
    output logic [gpioPkg::spdEmopsCtrlWidth-1:0]      spdEmopsCtrl,
    output logic                                       liftHallPwrEnN,
    output logic [gpioPkg::adcSelWidth-1:0]            adcSel,
    output logic [gpioPkg::adcMuxCount-1:0]            adcMuxN
);

    gpioRegBusIf regBus ();

    opbStrobeDecode i_opbStrobeDecode (
        .powerWe      (powerWe),
        .gantry96vWe  (gantry96vWe),
        .spdEmopsWe   (spdEmopsWe),
        .liftSensorWe (liftSensorWe),
        .adcSelWe     (adcSelWe),
        .powerRe      (powerRe),
        .gantry96vRe  (gantry96vRe),
        .spdEmopsRe   (spdEmopsRe),
        .liftSensorRe (liftSensorRe),
        .adcSelRe     (adcSelRe),
        .opbDi        (opbDi),
        .regBus       (regBus.decode)
    );

    gpioRegisterBank i_gpioRegisterBank (
        .OPB_CLK          (OPB_CLK),
        .OPB_RST          (OPB_RST),
        .regBus           (regBus.bank),
        .powerStatus      (powerStatus),
        .gantry96vStatus  (gantry96vStatus),
        .spdEmopsStatus   (spdEmopsStatus),
        .liftSensorStatus (liftSensorStatus),
        .powerCtrl        (powerCtrl),
        .gantry96vCtrl    (gantry96vCtrl),
        .spdEmopsCtrl     (spdEmopsCtrl),
        .liftHallPwrEnN   (liftHallPwrEnN),
        .adcSel           (adcSel),
        .adcMuxN          (adcMuxN)
    );

    opbReadResult i_opbReadResult (
        .OPB_CLK (OPB_CLK),
        .OPB_RST (OPB_RST),
        .regBus  (regBus.result),
        .opbDo   (opbDo)
    );

endmodule

// File: logic/opbReadResult.sv
/*
 * OPB read result
 *   Registers the selected group word onto the read data bus
 */
`timescale 1ns/1ns

module opbReadResult (
    input  logic              OPB_CLK,
    input  logic              OPB_RST,
    gpioRegBusIf.result       regBus,
    output gpioPkg::regWordT  opbDo
);
    import gpioPkg::*;

    // One cycle latency, word from before the edge
    always_ff @(posedge OPB_CLK or posedge OPB_RST) begin
        if (OPB_RST) begin
            opbDo <= '0;
        end else if (regBus.rdSel == grpNone) begin
            // Idle bus reads back zero
            opbDo <= '0;
        end else begin
            opbDo <= regBus.regFile[regBus.rdSel];
        end
    end

endmodule

// File: logic/gpioRegisterBank.sv
/*
 * GPIO register bank
 *   Five group words with reset values
 *   Control half written from the bus, status half sampled from pins
 *   Control pin outputs and ADC multiplexer enable decode
 */
`timescale 1ns/1ns

module gpioRegisterBank (
    input  logic                                       OPB_CLK,
    input  logic                                       OPB_RST,
    gpioRegBusIf.bank                                  regBus,
    input  logic [gpioPkg::powerStatusWidth-1:0]       powerStatus,
    input  logic [gpioPkg::gantry96vStatusWidth-1:0]   gantry96vStatus,
    input  logic [gpioPkg::spdEmopsStatusWidth-1:0]    spdEmopsStatus,
    input  logic [gpioPkg::liftSensorStatusWidth-1:0]  liftSensorStatus,
    output logic [gpioPkg::powerCtrlWidth-1:0]         powerCtrl,
    output logic [gpioPkg::gantry96vCtrlWidth-1:0]     gantry96vCtrl,
    output logic [gpioPkg::spdEmopsCtrlWidth-1:0]      spdEmopsCtrl,
    output logic                                       liftHallPwrEnN,
    output logic [gpioPkg::adcSelWidth-1:0]            adcSel,
    output logic [gpioPkg::adcMuxCount-1:0]            adcMuxN
);
    import gpioPkg::*;

    localparam int statusWidth = 32 - statusLsb;

    regWordT                groupReg [numGroups];
    logic [statusWidth-1:0] statusIn [numGroups];
    logic [adcMuxCount-1:0] adcMuxField;

    ////////////////////////////////////////
    // Status pins, zero padded per group
    ////////////////////////////////////////
    assign statusIn[grpPower]      = statusWidth'(powerStatus);
    assign statusIn[grpGantry96v]  = statusWidth'(gantry96vStatus);
    assign statusIn[grpSpdEmops]   = statusWidth'(spdEmopsStatus);
    assign statusIn[grpLiftSensor] = statusWidth'(liftSensorStatus);
    // ADC select has no status pins
    assign statusIn[grpAdcSel]     = '0;

    ////////////////////////////////////////
    // Registers
    ////////////////////////////////////////
    always_ff @(posedge OPB_CLK or posedge OPB_RST) begin
        if (OPB_RST) begin
            for (int g = 0; g < numGroups; g++) begin
                groupReg[g] <= regResetValues[g];
            end
        end else begin
            for (int g = 0; g < numGroups; g++) begin
                // Status is held while the group is being written
                if (regBus.wrMask[g]) begin
                    groupReg[g][ctrlWidth-1:0] <= regBus.wrData;
                end else begin
                    groupReg[g][31:statusLsb] <= statusIn[g];
                end
            end
        end
    end

    assign regBus.regFile = groupReg;

    ////////////////////////////////////////
    // Control pins
    ////////////////////////////////////////
    assign powerCtrl      = groupReg[grpPower][powerCtrlWidth-1:0];
    assign gantry96vCtrl  = groupReg[grpGantry96v][gantry96vCtrlWidth-1:0];
    assign spdEmopsCtrl   = groupReg[grpSpdEmops][spdEmopsCtrlWidth-1:0];
    // Active low, high out of reset
    assign liftHallPwrEnN = groupReg[grpLiftSensor][0];
    assign adcSel         = groupReg[grpAdcSel][adcSelWidth-1:0];

    // Mux field sits just above the select lines
    assign adcMuxField = groupReg[grpAdcSel][adcSelWidth +: adcMuxCount];

    // A line goes low only on an exact code match
    always_comb begin
        for (int m = 0; m < adcMuxCount; m++) begin
            adcMuxN[m] = (adcMuxField != adcMuxCodes[m]);
        end
    end

endmodule

// File: logic/opbStrobeDecode.sv
/*
 * OPB strobe decode
 *   Packs per-group write strobes into a write mask
 *   Priority-encodes read strobes into a group select
 */
`timescale 1ns/1ns

module opbStrobeDecode (
    input  logic             powerWe,
    input  logic             gantry96vWe,
    input  logic             spdEmopsWe,
    input  logic             liftSensorWe,
    input  logic             adcSelWe,
    input  logic             powerRe,
    input  logic             gantry96vRe,
    input  logic             spdEmopsRe,
    input  logic             liftSensorRe,
    input  logic             adcSelRe,
    input  gpioPkg::regWordT opbDi,
    gpioRegBusIf.decode      regBus
);
    import gpioPkg::*;

    // Several groups may be written in one cycle
    assign regBus.wrMask[grpPower]      = powerWe;
    assign regBus.wrMask[grpGantry96v]  = gantry96vWe;
    assign regBus.wrMask[grpSpdEmops]   = spdEmopsWe;
    assign regBus.wrMask[grpLiftSensor] = liftSensorWe;
    assign regBus.wrMask[grpAdcSel]     = adcSelWe;

    // Only the control half is writable
    assign regBus.wrData = opbDi[ctrlWidth-1:0];

    // Lowest group wins
    always_comb begin
        if (powerRe) begin
            regBus.rdSel = grpPower;
        end else if (gantry96vRe) begin
            regBus.rdSel = grpGantry96v;
        end else if (spdEmopsRe) begin
            regBus.rdSel = grpSpdEmops;
        end else if (liftSensorRe) begin
            regBus.rdSel = grpLiftSensor;
        end else if (adcSelRe) begin
            regBus.rdSel = grpAdcSel;
        end else begin
            regBus.rdSel = grpNone;
        end
    end

endmodule

// File: logic/gpioRegBusIf.sv
/*
 * Register bus between strobe decode, register bank and read result
 *   Write mask and data toward the bank
 *   Read select and register contents toward the result stage
 */
`timescale 1ns/1ns

interface gpioRegBusIf;
    import gpioPkg::*;

    // One bit per group, indexed by gpioGroupE
    logic [numGroups-1:0] wrMask;
    logic [ctrlWidth-1:0] wrData;
    gpioGroupE            rdSel;
    regWordT              regFile [numGroups];

    modport decode (
        output wrMask, wrData, rdSel
    );

    modport bank (
        input  wrMask, wrData,
        output regFile
    );

    modport result (
        input rdSel, regFile
    );

endinterface

// File: logic/gpioPkg.sv
/*
 * Shared definitions for the OPB GPIO register block
 *   gpioGroupE     register group selected for a read
 *   regWordT       32-bit register word, control and status halves
 *   Per-group control and status widths, reset words
 *   ADC select widths and multiplexer enable codes
 */
package gpioPkg;

    ////////////////////////////////////////
    // Groups and register layout
    ////////////////////////////////////////
    typedef enum logic [2:0] {
        grpPower,
        grpGantry96v,
        grpSpdEmops,
        grpLiftSensor,
        grpAdcSel,
        grpNone
    } gpioGroupE;

    localparam int numGroups = 5;

    typedef logic [31:0] regWordT;

    localparam int ctrlWidth = 16;
    localparam int statusLsb = 16;

    // Indexed by gpioGroupE
    localparam regWordT regResetValues [numGroups] = '{
        32'h0000_0000,
        32'h0000_0000,
        32'h0000_0010,
        32'h0000_0001,
        32'h0000_00F8
    };

    ////////////////////////////////////////
    // Pin widths
    ////////////////////////////////////////
    localparam int powerCtrlWidth        = 2;
    localparam int powerStatusWidth      = 2;
    localparam int gantry96vCtrlWidth    = 3;
    localparam int gantry96vStatusWidth  = 8;
    localparam int spdEmopsCtrlWidth     = 6;
    localparam int spdEmopsStatusWidth   = 8;
    localparam int liftSensorStatusWidth = 4;

    localparam int adcSelWidth = 3;
    localparam int adcMuxCount = 5;

    // Bits 7:3 of the ADC word that enable mux 1 to 5
    localparam logic [adcMuxCount-1:0] adcMuxCodes [adcMuxCount] = '{
        5'b11110,
        5'b11101,
        5'b11011,
        5'b10111,
        5'b01111
    };

endpackage
